// File: design/spi_pkg.sv
package spi_pkg;

	// bus geometry
	localparam int data_n = 8;
	localparam int periph_n = 2;

	// register map, address 3 is unmapped and reads as zero
	localparam logic [periph_n - 1 : 0] addr_ctrl = 2'd0;
	localparam logic [periph_n - 1 : 0] addr_stat = 2'd1;
	localparam logic [periph_n - 1 : 0] addr_data = 2'd2;

	// readable bits, bit 3 of control is reserved
	localparam logic [data_n - 1 : 0] ctrl_mask = 8'hf7;
	localparam logic [data_n - 1 : 0] stat_mask = 8'h03;

	// status bit positions
	localparam int stat_busy_bit = 0;
	localparam int stat_done_bit = 1;

	// prescaler counter width and select width
	localparam int pr_n = 8;
	localparam int pr_sel_n = 3;

	// two sck edges per data bit
	localparam int sck_edges = 2 * data_n;
	localparam int edge_cnt_n = $clog2(sck_edges);

	// control word as seen by the hardware, msb first
	typedef struct packed {
		logic en;
		logic ie;
		logic cpol;
		logic cpha;
		logic rsvd;
		logic [pr_sel_n - 1 : 0] pr_sel;
	} spi_ctrl_fields_t;

	// control word, written as a bus word and decoded as fields
	typedef union packed {
		logic [data_n - 1 : 0] raw;
		spi_ctrl_fields_t fields;
	} spi_ctrl_t;

endpackage

// File: design/spi_regs.sv
`timescale 1ns/1ns

module spi_regs (
	input logic clk,
	input logic n_reset,
	input logic bus_we,
	input logic bus_oe,
	input logic periph_sel,
	input logic [spi_pkg::periph_n - 1 : 0] periph_addr,
	input logic [spi_pkg::data_n - 1 : 0] bus_wdata,
	output logic [spi_pkg::data_n - 1 : 0] bus_rdata,
	output spi_pkg::spi_ctrl_t ctrl,
	output logic [spi_pkg::data_n - 1 : 0] tx_data,
	output logic start,
	input logic busy,
	input logic finish,
	input logic [spi_pkg::data_n - 1 : 0] rx_data,
	output logic interrupt
);

	import spi_pkg::*;

	logic we;
	logic oe;
	logic ctrl_wr;
	logic tx_accept;
	logic rx_rd;
	logic done;
	logic [data_n - 1 : 0] rx_word;
	logic [data_n - 1 : 0] stat;

	// bus strobes only count while this peripheral is selected
	assign we = periph_sel & bus_we;
	assign oe = periph_sel & bus_oe;

	assign ctrl_wr = we && (periph_addr == addr_ctrl);

	// a tx write is dropped while disabled or while a transfer is pending
	// start is included so a write right behind start cannot slip in
	// before busy rises
	assign tx_accept = we && (periph_addr == addr_data) && ctrl.fields.en
		&& !busy && !start;

	// reading the rx word acknowledges the transfer
	assign rx_rd = oe && (periph_addr == addr_data);

	always_comb begin
		stat = '0;
		stat[stat_busy_bit] = busy;
		stat[stat_done_bit] = done;
	end

	// read mux
	always_comb begin
		bus_rdata = '0;
		if (oe) begin
			case (periph_addr)
				addr_ctrl: begin
					bus_rdata = ctrl.raw & ctrl_mask;
				end
				addr_stat: begin
					bus_rdata = stat & stat_mask;
				end
				addr_data: begin
					bus_rdata = rx_word;
				end
				default: begin
					bus_rdata = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			ctrl <= '0;
			tx_data <= '0;
			rx_word <= '0;
			start <= 1'b0;
			done <= 1'b0;
		end else begin
			// start is the registered accept, tx_data is valid alongside it
			start <= tx_accept;
			if (ctrl_wr) begin
				ctrl.raw <= bus_wdata;
			end
			if (tx_accept) begin
				tx_data <= bus_wdata;
			end
			if (finish) begin
				rx_word <= rx_data;
			end
			// a finishing transfer wins over a read on the same edge
			if (finish) begin
				done <= 1'b1;
			end else if (rx_rd) begin
				done <= 1'b0;
			end
		end
	end

	// level interrupt, masked by ie
	assign interrupt = done & ctrl.fields.ie;

endmodule

// File: design/spi_prescaler.sv
`timescale 1ns/1ns

module spi_prescaler (
	input logic clk,
	input logic n_reset,
	input logic start,
	input logic [spi_pkg::pr_sel_n - 1 : 0] pr_sel,
	output logic tick
);

	import spi_pkg::*;

	logic [pr_n - 1 : 0] cnt;
	logic [pr_n - 1 : 0] div_mask;

	// low pr_sel bits of the counter, all ones once per 2^pr_sel cycles
	assign div_mask = (pr_n'(1) << pr_sel) - pr_n'(1);

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			cnt <= '0;
		end else if (start) begin
			// realign so the first tick lands 2^pr_sel cycles after start
			cnt <= '0;
		end else begin
			cnt <= cnt + pr_n'(1);
		end
	end

	// pr_sel 0 gives an empty mask and a tick every cycle
	assign tick = (cnt & div_mask) == div_mask;

endmodule

// File: design/spi_shifter.sv
`timescale 1ns/1ns

module spi_shifter (
	input logic clk,
	input logic n_reset,
	input logic start,
	input logic tick,
	input logic cpol,
	input logic cpha,
	input logic [spi_pkg::data_n - 1 : 0] tx_data,
	input logic miso,
	output logic busy,
	output logic finish,
	output logic [spi_pkg::data_n - 1 : 0] rx_data,
	output logic cs,
	output logic sck,
	output logic mosi
);

	import spi_pkg::*;

	logic phase;
	logic [edge_cnt_n - 1 : 0] edge_cnt;
	logic [data_n - 1 : 0] sh;
	logic step;
	logic sample_edge;
	logic last_edge;

	// one sck edge per prescaler tick while a transfer runs
	assign step = busy && tick;

	// edge_cnt[0] low marks the first edge of a pair
	// cpha 0 samples on the first edge, cpha 1 on the second
	assign sample_edge = edge_cnt[0] == cpha;

	assign last_edge = edge_cnt == edge_cnt_n'(sck_edges - 1);

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			busy <= 1'b0;
			finish <= 1'b0;
			cs <= 1'b0;
			phase <= 1'b0;
			edge_cnt <= '0;
			mosi <= 1'b0;
		end else begin
			finish <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cs <= 1'b1;
				phase <= 1'b0;
				edge_cnt <= '0;
				// msb is presented as soon as cs rises
				mosi <= tx_data[data_n - 1];
			end else if (step) begin
				phase <= ~phase;
				edge_cnt <= edge_cnt + edge_cnt_n'(1);
				if (!sample_edge) begin
					mosi <= sh[data_n - 1];
				end
				if (last_edge) begin
					busy <= 1'b0;
					finish <= 1'b1;
				end
			end else if (finish) begin
				// cs drops one cycle after busy
				cs <= 1'b0;
			end
		end
	end

	// shift register, rx bits enter from the bottom as tx bits leave the top
	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			sh <= '0;
		end else if (start) begin
			sh <= tx_data;
		end else if (step && sample_edge) begin
			sh <= {sh[data_n - 2 : 0], miso};
		end
	end

	// 16 toggles bring phase back to zero, so sck rests at cpol
	assign sck = phase ^ cpol;

	// after the last sample edge the whole reply sits in sh
	assign rx_data = sh;

endmodule

// File: design/spi.sv
`timescale 1ns/1ns

module spi (
	input logic clk,
	input logic n_reset,
	input logic bus_we,
	input logic bus_oe,
	input logic periph_sel,
	input logic [spi_pkg::periph_n - 1 : 0] periph_addr,
	input logic [spi_pkg::data_n - 1 : 0] bus_wdata,
	output logic [spi_pkg::data_n - 1 : 0] bus_rdata,
	output logic interrupt,
	input logic miso,
	output logic cs,
	output logic mosi,
	output logic sck
);

	import spi_pkg::*;

	spi_ctrl_t ctrl;
	logic [data_n - 1 : 0] tx_data;
	logic [data_n - 1 : 0] rx_data;
	logic start;
	logic tick;
	logic busy;
	logic finish;

	// register file and bus decode
	spi_regs regs (
		.clk(clk),
		.n_reset(n_reset),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.periph_sel(periph_sel),
		.periph_addr(periph_addr),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.ctrl(ctrl),
		.tx_data(tx_data),
		.start(start),
		.busy(busy),
		.finish(finish),
		.rx_data(rx_data),
		.interrupt(interrupt)
	);

	// bit rate enable
	spi_prescaler prescaler (
		.clk(clk),
		.n_reset(n_reset),
		.start(start),
		.pr_sel(ctrl.fields.pr_sel),
		.tick(tick)
	);

	// transfer engine and pins
	spi_shifter shifter (
		.clk(clk),
		.n_reset(n_reset),
		.start(start),
		.tick(tick),
		.cpol(ctrl.fields.cpol),
		.cpha(ctrl.fields.cpha),
		.tx_data(tx_data),
		.miso(miso),
		.busy(busy),
		.finish(finish),
		.rx_data(rx_data),
		.cs(cs),
		.sck(sck),
		.mosi(mosi)
	);

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic n_reset
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// reset held low for three rising edges
	initial begin
		n_reset <= 1'b0;
		repeat (3) @(posedge clk);
		n_reset <= 1'b1;
	end

endmodule

// File: dv/spi_sva.sv
`timescale 1ns/1ns

module spi_sva (
	input logic clk,
	input logic n_reset,
	input logic start,
	input logic busy,
	input logic cs,
	input logic sck,
	input spi_pkg::spi_ctrl_t ctrl
);

	// cs follows busy down one cycle later and stays low while idle
	cs_idle: assert property (@(posedge clk) disable iff (!n_reset)
		!busy ##1 !busy |-> !cs)
	else $error("cs high with no transfer running");

	// sck rests at the polarity bit outside a transfer
	sck_idle: assert property (@(posedge clk) disable iff (!n_reset)
		!cs |-> sck == ctrl.fields.cpol)
	else $error("sck away from cpol while cs is low");

	no_restart: assert property (@(posedge clk) disable iff (!n_reset)
		start |-> !busy)
	else $error("start pulsed during a transfer");

endmodule

bind spi spi_sva sva (
	.clk(clk),
	.n_reset(n_reset),
	.start(start),
	.busy(busy),
	.cs(cs),
	.sck(sck),
	.ctrl(ctrl)
);

// File: dv/spi_tb.sv
`timescale 1ns/1ns

module spi_tb;

	import spi_pkg::*;

	localparam int n_transfers = 40;
	localparam int poll_limit = 200;
	localparam int cycle_limit = 100;

	logic clk;
	logic n_reset;
	logic bus_we;
	logic bus_oe;
	logic periph_sel;
	logic [periph_n - 1 : 0] periph_addr;
	logic [data_n - 1 : 0] bus_wdata;
	logic [data_n - 1 : 0] bus_rdata;
	logic interrupt;
	logic miso = 1'b0;
	logic cs;
	logic mosi;
	logic sck;

	int n_checks = 0;
	int n_errors = 0;
	int n_timeouts = 0;

	// slave model state
	logic slave_cpol;
	logic slave_cpha;
	logic [data_n - 1 : 0] slave_reply;
	logic [data_n - 1 : 0] slave_out = '0;
	logic [data_n - 1 : 0] slave_in = '0;
	int slave_edges = 0;
	int cs_rises = 0;
	logic cs_q = 1'b0;
	logic sck_q = 1'b0;

	tb_clock clock_gen (.clk(clk), .n_reset(n_reset));

	spi dut (
		.clk(clk),
		.n_reset(n_reset),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.periph_sel(periph_sel),
		.periph_addr(periph_addr),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.interrupt(interrupt),
		.miso(miso),
		.cs(cs),
		.mosi(mosi),
		.sck(sck)
	);

	// spi slave, reacts to the pins so miso settles well before the next clk edge
	always @(cs or sck) begin
		if (cs && !cs_q) begin
			cs_rises = cs_rises + 1;
			slave_edges = 0;
			slave_in = '0;
			slave_out = slave_reply;
			// cpha 0 presents the first bit as soon as cs rises
			if (!slave_cpha) begin
				miso <= slave_out[data_n - 1];
				slave_out = slave_out << 1;
			end
		end else if (cs && sck != sck_q) begin
			slave_edges = slave_edges + 1;
			// a leading edge leaves the idle level
			if ((sck != slave_cpol) != slave_cpha) begin
				slave_in = {slave_in[data_n - 2 : 0], mosi};
			end else begin
				miso <= slave_out[data_n - 1];
				slave_out = slave_out << 1;
			end
		end
		cs_q = cs;
		sck_q = sck;
	end

	task automatic check_value(input string what, input logic [data_n - 1 : 0] got,
		input logic [data_n - 1 : 0] expected);
		n_checks++;
		if (got !== expected) begin
			n_errors++;
			$display("ERROR %0t ns: %s is %02h, expected %02h", $time, what, got, expected);
		end
	endtask

	task automatic end_run();
		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		n_timeouts++;
		$display("gave up at %0t ns waiting for %s", $time, what);
		end_run();
	endtask

	task automatic bus_write(input logic [periph_n - 1 : 0] addr,
		input logic [data_n - 1 : 0] data);
		@(posedge clk);
		periph_sel <= 1'b1;
		bus_we <= 1'b1;
		periph_addr <= addr;
		bus_wdata <= data;
		@(posedge clk);
		periph_sel <= 1'b0;
		bus_we <= 1'b0;
	endtask

	// read data is taken mid cycle, before the edge that ends the access
	task automatic bus_read(input logic [periph_n - 1 : 0] addr,
		output logic [data_n - 1 : 0] data);
		@(posedge clk);
		periph_sel <= 1'b1;
		bus_oe <= 1'b1;
		periph_addr <= addr;
		@(negedge clk);
		data = bus_rdata;
		@(posedge clk);
		periph_sel <= 1'b0;
		bus_oe <= 1'b0;
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!n_reset && cycles < cycle_limit);
		if (!n_reset) begin
			report_timeout("reset release");
		end
	endtask

	task automatic wait_idle(output logic [data_n - 1 : 0] st);
		int polls;
		polls = 0;
		bus_read(addr_stat, st);
		while (st[stat_busy_bit] && polls < poll_limit) begin
			bus_read(addr_stat, st);
			polls++;
		end
		if (st[stat_busy_bit]) begin
			report_timeout("busy to clear");
		end
	endtask

	task automatic wait_cs_low();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (cs && cycles < cycle_limit);
		if (cs) begin
			report_timeout("cs to fall");
		end
	endtask

	// control bits: en 7, ie 6, cpol 5, cpha 4
	task automatic transfer(input logic [data_n - 1 : 0] ctrl, input logic [data_n - 1 : 0] tx,
		input logic [data_n - 1 : 0] reply, input logic late_write);
		logic [data_n - 1 : 0] rd;
		int rises;
		bus_write(addr_ctrl, ctrl);
		slave_cpol = ctrl[5];
		slave_cpha = ctrl[4];
		slave_reply = reply;
		rises = cs_rises;
		bus_write(addr_data, tx);
		if (late_write) begin
			// lands while busy, must not reach the pins
			bus_write(addr_data, ~tx);
		end
		wait_idle(rd);
		// done is registered from finish and lands with the fall of cs
		wait_cs_low();
		bus_read(addr_stat, rd);
		// done set, busy clear
		check_value("status after transfer", rd, 8'h02);
		@(negedge clk);
		check_value("interrupt with done set", 8'(interrupt), 8'(ctrl[6]));
		check_value("byte seen by slave", slave_in, tx);
		check_value("sck edges", 8'(slave_edges), 8'd16);
		check_value("cs pulses", 8'(cs_rises - rises), 8'd1);
		check_value("idle sck", 8'(sck), 8'(ctrl[5]));
		bus_read(addr_data, rd);
		check_value("rx data", rd, reply);
		bus_read(addr_stat, rd);
		check_value("status after rx read", rd, 8'h00);
		@(negedge clk);
		check_value("interrupt after rx read", 8'(interrupt), 8'h00);
	endtask

	initial begin
		logic [data_n - 1 : 0] rd;
		logic [data_n - 1 : 0] v;
		logic [data_n - 1 : 0] last_reply;
		int rises;
		void'($urandom(32'h313));
		bus_we <= 1'b0;
		bus_oe <= 1'b0;
		periph_sel <= 1'b0;
		periph_addr <= '0;
		bus_wdata <= '0;
		slave_cpol = 1'b0;
		slave_cpha = 1'b0;
		slave_reply = '0;
		last_reply = '0;
		wait_reset();

		bus_read(addr_ctrl, rd);
		check_value("ctrl after reset", rd, 8'h00);
		bus_read(addr_stat, rd);
		check_value("status after reset", rd, 8'h00);
		bus_read(addr_data, rd);
		check_value("data after reset", rd, 8'h00);
		bus_read(2'd3, rd);
		check_value("unmapped address", rd, 8'h00);
		@(negedge clk);
		check_value("interrupt after reset", 8'(interrupt), 8'h00);
		check_value("cs after reset", 8'(cs), 8'h00);
		check_value("sck after reset", 8'(sck), 8'h00);

		// reserved bit 3 reads back as zero
		repeat (12) begin
			v = 8'($urandom);
			bus_write(addr_ctrl, v);
			bus_read(addr_ctrl, rd);
			check_value("ctrl readback", rd, {v[7:4], 1'b0, v[2:0]});
		end

		// en set, pr_sel kept in 0..3
		repeat (n_transfers) begin
			v = 8'($urandom);
			v[7] = 1'b1;
			v[2] = 1'b0;
			last_reply = 8'($urandom);
			transfer(v, 8'($urandom), last_reply, 1'b0);
		end

		// data write with en clear goes nowhere
		v = 8'($urandom);
		v[7] = 1'b0;
		bus_write(addr_ctrl, v);
		rises = cs_rises;
		bus_write(addr_data, 8'($urandom));
		repeat (4) begin
			bus_read(addr_stat, rd);
			check_value("status while disabled", rd, 8'h00);
		end
		check_value("cs pulses while disabled", 8'(cs_rises - rises), 8'd0);
		bus_read(addr_data, rd);
		check_value("rx data while disabled", rd, last_reply);

		repeat (4) begin
			v = 8'($urandom);
			v[7] = 1'b1;
			v[2] = 1'b0;
			transfer(v, 8'($urandom), 8'($urandom), 1'b1);
		end

		end_run();
	end

endmodule

// File: src.f
design/spi_pkg.sv
design/spi_regs.sv
design/spi_prescaler.sv
design/spi_shifter.sv
design/spi.sv
dv/tb_clock.sv
dv/spi_sva.sv
dv/spi_tb.sv

// File: Makefile
# Verilator build and run of the SPI master testbench

SIM := obj_dir/Vspi_tb

all: run

$(SIM): src.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --assert --top-module spi_tb -f src.f -o Vspi_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Checks failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
